/* hw/glm_params.svh */
`ifndef GLM_PARAMS_SVH
`define GLM_PARAMS_SVH

// line and word geometry
`define GLM_LINE_W      512
`define GLM_WORD_W      32
`define GLM_ADDR_W      42
`define GLM_PC_W        16
`define GLM_LOG2_PROG   8
`define GLM_NUM_CLASSES 6
`define GLM_NUM_IDX     3

// word positions inside an instruction line
`define GLM_W_ARG0      3
`define GLM_W_ARG1      4
`define GLM_W_STRIDE0   10
`define GLM_W_CMP       13
`define GLM_W_TARGET    14
`define GLM_W_OPCODE    15
`define GLM_NB_BIT      8

// special codes
`define GLM_PC_HALT     16'hFFFF
`define GLM_IDX_KEEP    32'hFFFFFFFF
`define GLM_IDX_INC     32'h0FFFFFFF
`define GLM_IDX_DEC     32'h01FFFFFF

`endif

/* hw/glm_pkg.sv */
`include "glm_params.svh"

package glm_pkg;

    // one program line, word 0 in the low bits
    typedef logic [`GLM_LINE_W/`GLM_WORD_W-1:0][`GLM_WORD_W-1:0] line_t;

    // the three index register values
    typedef logic [`GLM_NUM_IDX-1:0][`GLM_WORD_W-1:0] idx_vec_t;

    // one bit per operation class
    typedef logic [`GLM_NUM_CLASSES-1:0] class_vec_t;

    // program command from the host
    typedef struct packed {
        logic [`GLM_ADDR_W-1:0] addr;
        logic [15:0]            length;
    } prog_cmd_t;

    // host read channel
    typedef struct packed {
        logic                   valid;
        logic [`GLM_ADDR_W-1:0] addr;
    } host_rd_req_t;

    typedef struct packed {
        logic  valid;
        line_t data;
    } host_rd_rsp_t;

    // program memory ports
    typedef struct packed {
        logic                      en;
        logic [`GLM_LOG2_PROG-1:0] addr;
        line_t                     data;
    } prog_wr_t;

    typedef struct packed {
        logic  valid;
        line_t data;
    } prog_rd_t;

    // arguments handed to an engine at dispatch
    typedef struct packed {
        idx_vec_t               idx;
        logic [`GLM_WORD_W-1:0] arg0;
        logic [`GLM_WORD_W-1:0] arg1;
    } op_args_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_LINE,
        DECODE,
        EXECUTE,
        DONE
    } seq_state_t;

endpackage

/* hw/program_memory.sv */
`timescale 1ns/1ns
`include "glm_params.svh"

module program_memory
(
    input  logic                      clk,
    input  glm_pkg::prog_wr_t         wr,
    input  logic                      rd_en,
    input  logic [`GLM_LOG2_PROG-1:0] rd_addr,
    output glm_pkg::prog_rd_t         rd
);

    glm_pkg::line_t mem [0:(1 << `GLM_LOG2_PROG)-1];

    // write port, loader side
    always_ff @(posedge clk)
    begin
        if (wr.en)
        begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk)
    begin
        rd.valid <= rd_en;
        if (rd_en)
        begin
            rd.data <= mem[rd_addr];
        end
    end

endmodule

/* hw/program_loader.sv */
`timescale 1ns/1ns
`include "glm_params.svh"

module program_loader
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  glm_pkg::prog_cmd_t    cmd,
    input  logic                  host_rd_almost_full,
    output glm_pkg::host_rd_req_t host_rd_req,
    input  glm_pkg::host_rd_rsp_t host_rd_rsp,
    output glm_pkg::prog_wr_t     prog_wr,
    output logic                  program_loaded
);

    logic               busy;
    glm_pkg::prog_cmd_t cmd_q;
    logic [15:0]        req_count;
    logic [15:0]        rsp_count;
    logic               req_go;
    logic               rsp_go;

    // request side stalls on almost_full, count is kept
    assign req_go = busy && (req_count < cmd_q.length) && !host_rd_almost_full;
    // responses come back in order, one line each
    assign rsp_go = busy && host_rd_rsp.valid && (rsp_count < cmd_q.length);

    // ======================================
    // command latch and completion
    // ======================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            program_loaded <= 1'b0;
            req_count <= '0;
            rsp_count <= '0;
        end
        else
        begin
            program_loaded <= 1'b0;
            if (!busy)
            begin
                if (start)
                begin
                    busy <= 1'b1;
                    cmd_q <= cmd;
                    req_count <= '0;
                    rsp_count <= '0;
                end
            end
            else if (rsp_count == cmd_q.length)
            begin
                // last write is in flight this cycle
                program_loaded <= 1'b1;
                busy <= 1'b0;
            end
            else
            begin
                if (req_go)
                begin
                    req_count <= req_count + 16'd1;
                end
                if (rsp_go)
                begin
                    rsp_count <= rsp_count + 16'd1;
                end
            end
        end
    end

    // ======================================
    // host requests and memory writes
    // ======================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            host_rd_req.valid <= 1'b0;
            prog_wr.en <= 1'b0;
        end
        else
        begin
            host_rd_req.valid <= req_go;
            prog_wr.en <= rsp_go;
        end
        host_rd_req.addr <= cmd_q.addr + `GLM_ADDR_W'(req_count);
        prog_wr.addr <= rsp_count[`GLM_LOG2_PROG-1:0];
        prog_wr.data <= host_rd_rsp.data;
    end

endmodule

/* hw/index_regs.sv */
`timescale 1ns/1ns
`include "glm_params.svh"

module index_regs
(
    input  logic                clk,
    input  logic                reset,
    input  logic                clear,
    input  logic                advance,
    input  glm_pkg::line_t      line,
    input  logic [3:0]          opclass,
    output glm_pkg::idx_vec_t   idx,
    output glm_pkg::op_args_t   args
);

    logic scaled;

    // keep, step up, step down, or load the code itself
    function automatic logic [`GLM_WORD_W-1:0] update_index
    (
        input logic [`GLM_WORD_W-1:0] code,
        input logic [`GLM_WORD_W-1:0] value
    );
        logic [`GLM_WORD_W-1:0] result;
        case (code)
            `GLM_IDX_KEEP: result = value;
            `GLM_IDX_INC:  result = value + 32'd1;
            `GLM_IDX_DEC:  result = value - 32'd1;
            default:       result = code;
        endcase
        return result;
    endfunction

    // update codes sit in words 0 to 2
    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            idx <= '0;
        end
        else if (advance)
        begin
            for (int i = 0; i < `GLM_NUM_IDX; i++)
            begin
                idx[i] <= update_index(line[i], idx[i]);
            end
        end
    end

    // memory access classes 1..3 get index times stride
    always_comb
    begin
        scaled = (opclass >= 4'd1) && (opclass <= 4'd3);
        for (int i = 0; i < `GLM_NUM_IDX; i++)
        begin
            args.idx[i] = scaled ? idx[i] * line[`GLM_W_STRIDE0 + i] : idx[i];
        end
        args.arg0 = line[`GLM_W_ARG0];
        args.arg1 = line[`GLM_W_ARG1];
    end

endmodule

/* hw/sequencer.sv */
`timescale 1ns/1ns
`include "glm_params.svh"

module sequencer
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        program_loaded,
    output logic                        rd_en,
    output logic [`GLM_LOG2_PROG-1:0]   rd_addr,
    input  glm_pkg::prog_rd_t           rd,
    output glm_pkg::line_t              line,
    input  glm_pkg::idx_vec_t           idx,
    input  glm_pkg::op_args_t           args,
    output logic                        idx_clear,
    output logic                        idx_advance,
    output logic [`GLM_NUM_CLASSES-1:0] op_start,
    output glm_pkg::op_args_t           op_args,
    input  logic [`GLM_NUM_CLASSES-1:0] op_done,
    output logic                        done
);

    glm_pkg::seq_state_t          state;
    logic [`GLM_PC_W-1:0]         pc;
    logic [`GLM_NUM_CLASSES-1:0]  pending;

    logic [3:0]                   opclass;
    logic [3:0]                   flow;
    logic                         nonblocking;
    logic                         is_op;
    logic [2:0]                   cls_idx;
    logic [`GLM_NUM_CLASSES-1:0]  cls_mask;
    logic                         blocked;
    logic                         at_halt;
    logic                         is_jump;
    logic [`GLM_WORD_W-1:0]       sel_idx;
    logic [`GLM_PC_W-1:0]         branch_pc;
    logic [`GLM_PC_W-1:0]         next_pc;

    // ======================================
    // decode of the latched line
    // ======================================
    always_comb
    begin
        opclass = line[`GLM_W_OPCODE][7:4];
        flow = line[`GLM_W_OPCODE][3:0];
        nonblocking = line[`GLM_W_OPCODE][`GLM_NB_BIT];
        is_op = (opclass != 4'd0) && (opclass <= 4'(`GLM_NUM_CLASSES));
        cls_idx = opclass[2:0] - 3'd1;
        cls_mask = is_op ? (glm_pkg::class_vec_t'(1) << cls_idx) : '0;

        // a done in the dispatch cycle itself releases the wait
        blocked = !nonblocking && (|(cls_mask & (pending | op_start) & ~op_done));
        at_halt = (pc == `GLM_PC_HALT);

        // jump on index 0, 1 or 2
        case (flow)
            4'd1: sel_idx = idx[0];
            4'd2: sel_idx = idx[1];
            4'd3: sel_idx = idx[2];
            default: sel_idx = '0;
        endcase
        is_jump = (flow >= 4'd1) && (flow <= 4'd3);
        // low half taken on match, high half otherwise
        if (sel_idx == line[`GLM_W_CMP])
        begin
            branch_pc = line[`GLM_W_TARGET][`GLM_PC_W-1:0];
        end
        else
        begin
            branch_pc = line[`GLM_W_TARGET][`GLM_WORD_W-1 -: `GLM_PC_W];
        end
        next_pc = is_jump ? branch_pc : pc + 1'b1;
    end

    assign rd_en = (state == glm_pkg::FETCH);
    assign rd_addr = pc[`GLM_LOG2_PROG-1:0];
    assign idx_clear = (state == glm_pkg::IDLE) && program_loaded;
    assign idx_advance = (state == glm_pkg::EXECUTE) && !blocked && !at_halt;
    assign done = (state == glm_pkg::DONE);

    // ======================================
    // control FSM
    // ======================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= glm_pkg::IDLE;
            pc <= '0;
            op_start <= '0;
            pending <= '0;
        end
        else
        begin
            op_start <= '0;
            pending <= (pending | op_start) & ~op_done;
            case (state)
                glm_pkg::IDLE:
                begin
                    if (program_loaded)
                    begin
                        pc <= '0;
                        state <= glm_pkg::FETCH;
                    end
                end

                glm_pkg::FETCH:
                begin
                    state <= glm_pkg::WAIT_LINE;
                end

                glm_pkg::WAIT_LINE:
                begin
                    if (rd.valid)
                    begin
                        state <= glm_pkg::DECODE;
                    end
                end

                glm_pkg::DECODE:
                begin
                    op_start <= cls_mask;
                    pc <= next_pc;
                    state <= glm_pkg::EXECUTE;
                end

                glm_pkg::EXECUTE:
                begin
                    if (!blocked)
                    begin
                        state <= at_halt ? glm_pkg::DONE : glm_pkg::FETCH;
                    end
                end

                glm_pkg::DONE:
                begin
                    state <= glm_pkg::IDLE;
                end

                default:
                begin
                    state <= glm_pkg::IDLE;
                end
            endcase
        end
    end

    // line and dispatch arguments
    always_ff @(posedge clk)
    begin
        if (state == glm_pkg::WAIT_LINE && rd.valid)
        begin
            line <= rd.data;
        end
        // held until the next dispatch
        if (state == glm_pkg::DECODE && is_op)
        begin
            op_args <= args;
        end
    end

endmodule

/* hw/glm_top.sv */
`timescale 1ns/1ns
`include "glm_params.svh"

module glm_top
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  glm_pkg::prog_cmd_t          cmd,
    input  logic                        host_rd_almost_full,
    output glm_pkg::host_rd_req_t       host_rd_req,
    input  glm_pkg::host_rd_rsp_t       host_rd_rsp,
    output logic [`GLM_NUM_CLASSES-1:0] op_start,
    output glm_pkg::op_args_t           op_args,
    input  logic [`GLM_NUM_CLASSES-1:0] op_done,
    output logic                        done
);

    glm_pkg::prog_wr_t          prog_wr;
    logic                       program_loaded;
    logic                       rd_en;
    logic [`GLM_LOG2_PROG-1:0]  rd_addr;
    glm_pkg::prog_rd_t          prog_rd;
    glm_pkg::line_t             seq_line;
    glm_pkg::idx_vec_t          idx;
    glm_pkg::op_args_t          args;
    logic                       idx_clear;
    logic                       idx_advance;

    // ======================================
    // program load path
    // ======================================
    program_loader program_loader_inst
    (
        .clk,
        .reset,
        .start,
        .cmd,
        .host_rd_almost_full,
        .host_rd_req,
        .host_rd_rsp,
        .prog_wr,
        .program_loaded
    );

    program_memory program_memory_inst
    (
        .clk,
        .wr(prog_wr),
        .rd_en,
        .rd_addr,
        .rd(prog_rd)
    );

    // ======================================
    // execution path
    // ======================================
    index_regs index_regs_inst
    (
        .clk,
        .reset,
        .clear(idx_clear),
        .advance(idx_advance),
        .line(seq_line),
        .opclass(seq_line[`GLM_W_OPCODE][7:4]),
        .idx,
        .args
    );

    sequencer sequencer_inst
    (
        .clk,
        .reset,
        .program_loaded,
        .rd_en,
        .rd_addr,
        .rd(prog_rd),
        .line(seq_line),
        .idx,
        .args,
        .idx_clear,
        .idx_advance,
        .op_start,
        .op_args,
        .op_done,
        .done
    );

endmodule

/* dv/glm_tb.sv */
`timescale 1ns/1ns
`include "glm_params.svh"

module glm_tb;

    logic                          clk;
    logic                          reset;
    logic                          start;
    glm_pkg::prog_cmd_t            cmd;
    logic                          host_rd_almost_full;
    glm_pkg::host_rd_req_t         host_rd_req;
    glm_pkg::host_rd_rsp_t         host_rd_rsp;
    logic [`GLM_NUM_CLASSES-1:0]   op_start;
    glm_pkg::op_args_t             op_args;
    logic [`GLM_NUM_CLASSES-1:0]   op_done;
    logic                          done;

    integer                        seed = 23920;
    string                         test_name = "reset";
    int                            cycle = 0;
    glm_pkg::line_t                host_mem [0:255];

    // host read channel bookkeeping
    logic [`GLM_ADDR_W-1:0]        req_base = '0;
    int                            req_len = 0;
    int                            req_seen = 0;
    logic [`GLM_ADDR_W-1:0]        rsp_addr_q [$];
    int                            rsp_due_q [$];
    int                            rsp_last_due = 0;

    // engine model and expected dispatches
    int                            eng_due [0:`GLM_NUM_CLASSES-1];
    logic [`GLM_NUM_CLASSES-1:0]   blk_mask = '0;
    bit                            nb_watch = 1'b0;
    int                            nb_class = 0;
    int                            exp_class [$];
    glm_pkg::op_args_t             exp_args [$];
    bit                            exp_nb [$];
    int                            pred_count [0:`GLM_NUM_CLASSES-1];
    int                            obs_count [0:`GLM_NUM_CLASSES-1];
    int                            done_count = 0;

    glm_top glm_top_inst
    (
        .clk,
        .reset,
        .start,
        .cmd,
        .host_rd_almost_full,
        .host_rd_req,
        .host_rd_rsp,
        .op_start,
        .op_args,
        .op_done,
        .done
    );

    always #4 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    // ========================================
    // program construction
    // ========================================
    function automatic glm_pkg::line_t make_instr
    (
        input logic [3:0] cls,
        input logic       nb,
        input logic [3:0] flow
    );
        glm_pkg::line_t l;
        l = '0;
        for (int s = 0; s < `GLM_NUM_IDX; s++)
        begin
            l[s] = `GLM_IDX_KEEP;
        end
        l[`GLM_W_OPCODE] = {23'd0, nb, cls, flow};
        return l;
    endfunction

    task fill_operands(inout glm_pkg::line_t l);
        l[`GLM_W_ARG0] = $random(seed);
        l[`GLM_W_ARG1] = $random(seed);
        for (int s = 0; s < `GLM_NUM_IDX; s++)
        begin
            l[`GLM_W_STRIDE0 + s] = $random(seed) & 32'h0000_00FF;
        end
    endtask

    task build_programs(output int loop_n);
        glm_pkg::line_t l;
        for (int a = 0; a < 256; a++)
        begin
            for (int w = 0; w < 16; w++)
            begin
                host_mem[a][w] = {16'hDEAD, 8'(a), 8'(w)};
            end
        end
        // straight line at 0x10, classes 1..6, two of them nonblocking
        for (int i = 0; i < 6; i++)
        begin
            l = make_instr(4'(i + 1), (i == 1 || i == 4), 4'd0);
            fill_operands(l);
            // rotate keep, inc, dec and load across the registers
            for (int s = 0; s < `GLM_NUM_IDX; s++)
            begin
                case ((i + s) % 4)
                    0: l[s] = `GLM_IDX_KEEP;
                    1: l[s] = `GLM_IDX_INC;
                    2: l[s] = `GLM_IDX_DEC;
                    default: l[s] = $random(seed) & 32'h0000_FFFF;
                endcase
            end
            host_mem[8'h10 + 8'(i)] = l;
        end
        l = make_instr(4'd0, 1'b0, 4'd1);
        l[`GLM_W_TARGET] = 32'hFFFF_FFFF;
        host_mem[8'h16] = l;

        // loop at 0x80, body repeats until idx0 matches
        loop_n = 3 + int'($unsigned($random(seed)) % 4);
        l = make_instr(4'd4, 1'b0, 4'd1);
        fill_operands(l);
        l[0] = `GLM_IDX_INC;
        l[1] = `GLM_IDX_INC;
        l[`GLM_W_CMP] = 32'(loop_n);
        l[`GLM_W_TARGET] = 32'h0000_0001;
        host_mem[8'h80] = l;
        l = make_instr(4'd1, 1'b0, 4'd0);
        fill_operands(l);
        host_mem[8'h81] = l;
        l = make_instr(4'd2, 1'b1, 4'd0);
        fill_operands(l);
        host_mem[8'h82] = l;
        l = make_instr(4'd3, 1'b0, 4'd0);
        fill_operands(l);
        l[2] = $random(seed) & 32'h0000_FFFF;
        host_mem[8'h83] = l;
        l = make_instr(4'd0, 1'b0, 4'd1);
        l[`GLM_W_TARGET] = 32'hFFFF_FFFF;
        host_mem[8'h84] = l;
    endtask

    // ========================================
    // reference interpreter
    // ========================================
    task automatic predict(input logic [`GLM_ADDR_W-1:0] base);
        glm_pkg::line_t    l;
        glm_pkg::op_args_t a;
        logic [31:0]       ix [0:2];
        logic [31:0]       code;
        logic [15:0]       pc;
        logic [15:0]       npc;
        int                cls;
        int                flow;
        int                steps;
        pc = '0;
        steps = 0;
        for (int i = 0; i < 3; i++)
        begin
            ix[i] = '0;
        end
        for (int c = 0; c < `GLM_NUM_CLASSES; c++)
        begin
            pred_count[c] = 0;
        end
        exp_class.delete();
        exp_args.delete();
        exp_nb.delete();
        while (pc != `GLM_PC_HALT && steps < 2000)
        begin
            l = host_mem[base[7:0] + pc[7:0]];
            cls = int'(l[`GLM_W_OPCODE][7:4]);
            flow = int'(l[`GLM_W_OPCODE][3:0]);
            if (cls >= 1 && cls <= `GLM_NUM_CLASSES)
            begin
                for (int i = 0; i < 3; i++)
                begin
                    a.idx[i] = (cls <= 3) ? ix[i] * l[`GLM_W_STRIDE0 + i] : ix[i];
                end
                a.arg0 = l[`GLM_W_ARG0];
                a.arg1 = l[`GLM_W_ARG1];
                exp_class.push_back(cls);
                exp_args.push_back(a);
                exp_nb.push_back(l[`GLM_W_OPCODE][`GLM_NB_BIT]);
                pred_count[cls - 1]++;
            end
            if (flow >= 1 && flow <= 3)
            begin
                npc = (ix[flow - 1] == l[`GLM_W_CMP]) ? l[`GLM_W_TARGET][15:0]
                                                      : l[`GLM_W_TARGET][31:16];
            end
            else
            begin
                npc = pc + 16'd1;
            end
            // no index update on the halting instruction
            if (npc != `GLM_PC_HALT)
            begin
                for (int i = 0; i < 3; i++)
                begin
                    code = l[i];
                    if (code == `GLM_IDX_INC)
                        ix[i] = ix[i] + 32'd1;
                    else if (code == `GLM_IDX_DEC)
                        ix[i] = ix[i] - 32'd1;
                    else if (code != `GLM_IDX_KEEP)
                        ix[i] = code;
                end
            end
            pc = npc;
            steps++;
        end
        assert (pc == `GLM_PC_HALT)
            else report_failure($sformatf("reference program of %s never halts", test_name));
    endtask

    // ========================================
    // host memory and engine models
    // ========================================
    task host_memory_step();
        logic [`GLM_ADDR_W-1:0] exp_addr;
        int                     due;
        if (host_rd_req.valid)
        begin
            exp_addr = req_base + `GLM_ADDR_W'(req_seen);
            // almost_full still holds the level sampled at the last edge
            assert (!host_rd_almost_full) else report_failure($sformatf(
                "%s: request issued while almost_full was high", test_name));
            assert (req_seen < req_len) else report_failure($sformatf(
                "%s: more requests than program lines", test_name));
            assert (host_rd_req.addr == exp_addr) else report_failure($sformatf(
                "FAIL %s: request address expected %h actual %h",
                test_name, exp_addr, host_rd_req.addr));
            due = cycle + 2 + int'($unsigned($random(seed)) % 4);
            if (due <= rsp_last_due)
                due = rsp_last_due + 1;
            rsp_last_due = due;
            rsp_addr_q.push_back(host_rd_req.addr);
            rsp_due_q.push_back(due);
            req_seen++;
        end
        host_rd_rsp.valid = 1'b0;
        if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle)
        begin
            host_rd_rsp.valid = 1'b1;
            host_rd_rsp.data = host_mem[rsp_addr_q[0][7:0]];
            void'(rsp_addr_q.pop_front());
            void'(rsp_due_q.pop_front());
        end
        host_rd_almost_full = ($unsigned($random(seed)) % 4) == 0;
    endtask

    task engine_step();
        int c;
        int delay;
        if (op_start != '0)
        begin
            assert ($onehot(op_start)) else report_failure($sformatf(
                "FAIL %s: op_start expected one hot actual %b", test_name, op_start));
            c = 0;
            for (int i = 0; i < `GLM_NUM_CLASSES; i++)
            begin
                if (op_start[i])
                    c = i;
            end
            assert (exp_class.size() > 0) else report_failure($sformatf(
                "%s: dispatch of class %0d after the predicted program ended", test_name, c + 1));
            assert (c + 1 == exp_class[0]) else report_failure($sformatf(
                "FAIL %s: class expected %0d actual %0d", test_name, exp_class[0], c + 1));
            assert (op_args == exp_args[0]) else report_failure($sformatf(
                "FAIL %s: op_args expected %h actual %h", test_name, exp_args[0], op_args));
            assert (blk_mask == '0) else report_failure($sformatf(
                "%s: dispatch before blocking classes %b were done", test_name, blk_mask));
            if (nb_watch)
            begin
                assert (eng_due[nb_class] != 0) else report_failure($sformatf(
                    "%s: nonblocking class %0d finished before the next dispatch",
                    test_name, nb_class + 1));
                nb_watch = 1'b0;
            end
            // a long nonblocking op keeps the engine busy past the next dispatch
            if (exp_nb[0])
            begin
                delay = 6;
                nb_watch = 1'b1;
                nb_class = c;
            end
            else
            begin
                delay = int'($unsigned($random(seed)) % 7);
                blk_mask[c] = 1'b1;
            end
            eng_due[c] = cycle + delay;
            obs_count[c]++;
            void'(exp_class.pop_front());
            void'(exp_args.pop_front());
            void'(exp_nb.pop_front());
        end
        for (int i = 0; i < `GLM_NUM_CLASSES; i++)
        begin
            op_done[i] = (eng_due[i] != 0) && (eng_due[i] == cycle);
            if (op_done[i])
            begin
                eng_due[i] = 0;
                blk_mask[i] = 1'b0;
            end
        end
    endtask

    // all models act 1 ns after the rising edge
    always
    begin
        @(posedge clk);
        #1;
        cycle = cycle + 1;
        if (reset)
        begin
            host_rd_almost_full = 1'b0;
            host_rd_rsp = '0;
            op_done = '0;
        end
        else
        begin
            host_memory_step();
            engine_step();
            if (done)
                done_count++;
        end
    end

    // ========================================
    // test sequence
    // ========================================
    task automatic run_program
    (
        input string                  name,
        input logic [`GLM_ADDR_W-1:0] base,
        input int                     len,
        input int                     runs
    );
        int   t;
        logic seen;
        test_name = name;
        predict(base);
        req_base = base;
        req_len = len;
        req_seen = 0;
        for (int c = 0; c < `GLM_NUM_CLASSES; c++)
        begin
            obs_count[c] = 0;
        end
        @(posedge clk);
        #1;
        start = 1'b1;
        cmd.addr = base;
        cmd.length = 16'(len);
        @(posedge clk);
        #1;
        start = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        // loader is busy, so this one must be dropped
        start = 1'b1;
        cmd.addr = base + `GLM_ADDR_W'(64);
        cmd.length = 16'd2;
        @(posedge clk);
        #1;
        start = 1'b0;

        seen = 1'b0;
        for (t = 0; t < 4000 && !seen; t++)
        begin
            @(negedge clk);
            seen = done;
        end
        if (!seen)
            report_failure($sformatf("%s: done never arrived, sequencer stuck in %s",
                test_name, glm_top_inst.sequencer_inst.state.name()));

        assert (req_seen == len) else report_failure($sformatf(
            "FAIL %s: requests expected %0d actual %0d", test_name, len, req_seen));
        assert (exp_class.size() == 0) else report_failure($sformatf(
            "FAIL %s: missing dispatches expected 0 actual %0d", test_name, exp_class.size()));
        for (int c = 0; c < `GLM_NUM_CLASSES; c++)
        begin
            assert (obs_count[c] == pred_count[c]) else report_failure($sformatf(
                "FAIL %s: class %0d dispatches expected %0d actual %0d",
                test_name, c + 1, pred_count[c], obs_count[c]));
        end
        repeat (8) @(negedge clk);
        assert (done_count == runs) else report_failure($sformatf(
            "FAIL %s: done pulses expected %0d actual %0d", test_name, runs, done_count));
    endtask

    initial
    begin
        int loop_n;
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        cmd = '0;
        host_rd_almost_full = 1'b0;
        host_rd_rsp = '0;
        op_done = '0;
        for (int c = 0; c < `GLM_NUM_CLASSES; c++)
        begin
            eng_due[c] = 0;
        end
        build_programs(loop_n);

        repeat (5) @(posedge clk);
        #1;
        assert (!host_rd_req.valid && op_start == '0 && !done
                && !glm_top_inst.program_loaded) else report_failure($sformatf(
            "FAIL reset: outputs expected 0000 actual %b%b%b%b", host_rd_req.valid,
            |op_start, done, glm_top_inst.program_loaded));
        reset = 1'b0;

        run_program("straight_line", 42'h3_0000_0010, 7, 1);
        // loop body runs loop_n + 1 times
        run_program("branch_loop", 42'h3_0000_0080, 5, 2);
        assert (obs_count[3] == loop_n + 1) else report_failure($sformatf(
            "FAIL branch_loop: body dispatches expected %0d actual %0d",
            loop_n + 1, obs_count[3]));

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hw
hw/glm_pkg.sv
hw/program_memory.sv
hw/program_loader.sv
hw/index_regs.sv
hw/sequencer.sv
hw/glm_top.sv
dv/glm_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module glm_tb --Mdir obj_dir -o glm_sim
	./obj_dir/glm_sim | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
